/* all.f */
design/chan_pkg.sv
design/pattern_sequencer.sv
design/pitch_lookup.sv
design/channel_controller.sv
design/tone_oscillator.sv
design/envelope_generator.sv
design/channel_mixer.sv
design/tracker_channel.sv
testbench/tracker_channel_tb.sv
testbench/tracker_channel_props.sv

/* design/chan_pkg.sv */
`default_nettype none

package chan_pkg;

  // Note index selects one of 16 pitches
  localparam int NOTE_W = 4;

  // Duration in note ticks
  localparam int DUR_W = 4;

  localparam int AMP_W = 7;
  localparam int DECAY_W = 3;

  // Phase accumulator and increment share one width
  localparam int PHASE_W = 12;

  // One pattern entry, note index in the top bits
  typedef struct packed {
    logic [NOTE_W-1:0]  note;
    logic [DUR_W-1:0]   duration;
    logic [AMP_W-1:0]   peak;
    logic [DECAY_W-1:0] decay;
  } note_entry_t;

  // Signed output sample, plus or minus the amplitude
  typedef logic signed [AMP_W:0] sample_t;

endpackage

`default_nettype wire

/* design/channel_controller.sv */
`default_nettype none
`timescale 1ns/10ps

module channel_controller (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire                          i_tick_stb,
  input  wire                          i_note_stb,
  output logic                         o_fetch,
  input  wire                          i_pattern_valid,
  input  wire chan_pkg::note_entry_t   i_entry,
  output logic                         o_pitch_enable,
  input  wire                          i_pitch_valid,
  input  wire [chan_pkg::PHASE_W-1:0]  i_phase_inc,
  note_if.ctrl                         note
);

  import chan_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_WAIT_PAT,
    ST_WAIT_PITCH,
    ST_LOAD
  } state_t;

  state_t             state, state_nxt;
  note_entry_t        entry_q;
  logic [PHASE_W-1:0] inc_q;
  logic [DUR_W-1:0]   dur_cnt;
  logic               note_tick;

  assign note_tick = i_tick_stb && i_note_stb;

  always_comb begin
    state_nxt      = state;
    o_fetch        = 1'b0;
    o_pitch_enable = 1'b0;
    case (state)
      ST_IDLE: begin
        // New note only once the current one has run out
        if (note_tick && dur_cnt == '0) begin
          state_nxt = ST_FETCH;
        end
      end
      ST_FETCH: begin
        o_fetch   = 1'b1;
        state_nxt = ST_WAIT_PAT;
      end
      ST_WAIT_PAT: begin
        if (i_pattern_valid) begin
          o_pitch_enable = 1'b1;
          state_nxt      = ST_WAIT_PITCH;
        end
      end
      ST_WAIT_PITCH: begin
        if (i_pitch_valid) begin
          state_nxt = ST_LOAD;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (o_pitch_enable) begin
      entry_q <= i_entry;
    end
    if (state == ST_WAIT_PITCH && i_pitch_valid) begin
      inc_q <= i_phase_inc;
    end
  end

  // Load strobe lands one cycle after the load state
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state          <= ST_IDLE;
      dur_cnt        <= '0;
      note.load      <= 1'b0;
      note.phase_inc <= '0;
      note.peak      <= '0;
      note.decay     <= '0;
    end else begin
      state     <= state_nxt;
      note.load <= (state == ST_LOAD);
      if (state == ST_LOAD) begin
        dur_cnt        <= entry_q.duration;
        note.phase_inc <= inc_q;
        note.peak      <= entry_q.peak;
        note.decay     <= entry_q.decay;
      end else if (state == ST_IDLE && note_tick && dur_cnt != '0) begin
        dur_cnt <= dur_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/channel_mixer.sv */
`default_nettype none
`timescale 1ns/10ps

module channel_mixer #(
  parameter int FIFO_DEPTH = 4,
  parameter int CREDIT_MAX = 4
) (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire                          i_tick_stb,
  input  wire                          i_polarity,
  input  wire [chan_pkg::AMP_W-1:0]    i_level,
  input  wire                          i_credit,
  output logic                         o_sample_valid,
  output chan_pkg::sample_t            o_sample,
  output logic                         o_overrun
);

  import chan_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int CRD_W = $clog2(CREDIT_MAX + 1);

  sample_t          fifo_mem [FIFO_DEPTH];
  sample_t          magnitude;
  sample_t          push_sample;
  logic             push_pend;
  logic             full;
  logic             push;
  logic             pop;
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] fill_cnt;
  logic [CRD_W-1:0] credit_cnt;

  assign magnitude = sample_t'({1'b0, i_level});
  assign full      = (fill_cnt == CNT_W'(FIFO_DEPTH));
  assign push      = push_pend && !full;
  assign pop       = o_sample_valid;

  // Send only with a credit in hand and something queued
  assign o_sample_valid = (credit_cnt != '0) && (fill_cnt != '0);
  assign o_sample       = fifo_mem[rd_ptr];

  // Capture the sample as it stood before the tick's update
  always_ff @(posedge i_clk) begin
    if (i_tick_stb) begin
      push_sample <= i_polarity ? magnitude : -magnitude;
    end
    if (push) begin
      fifo_mem[wr_ptr] <= push_sample;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      push_pend  <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_cnt   <= '0;
      credit_cnt <= '0;
      o_overrun  <= 1'b0;
    end else begin
      push_pend <= i_tick_stb;
      if (push_pend && full) begin
        o_overrun <= 1'b1;
      end
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        fill_cnt <= fill_cnt + 1'b1;
      end else if (pop && !push) begin
        fill_cnt <= fill_cnt - 1'b1;
      end
      // Grant and spend in one cycle cancel out
      if (i_credit && !pop && credit_cnt != CRD_W'(CREDIT_MAX)) begin
        credit_cnt <= credit_cnt + 1'b1;
      end else if (!i_credit && pop) begin
        credit_cnt <= credit_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/envelope_generator.sv */
`default_nettype none
`timescale 1ns/10ps

module envelope_generator (
  input  wire                        i_clk,
  input  wire                        i_rst,
  input  wire                        i_tick_stb,
  note_if.env                        note,
  output logic [chan_pkg::AMP_W-1:0] o_level
);

  import chan_pkg::*;

  logic [AMP_W-1:0] decay_step;
  logic [AMP_W-1:0] level_nxt;

  assign decay_step = AMP_W'(note.decay);

  // Linear decay that stops at zero
  always_comb begin
    if (o_level > decay_step) begin
      level_nxt = o_level - decay_step;
    end else begin
      level_nxt = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_level <= '0;
    end else if (note.load) begin
      o_level <= note.peak;
    end else if (i_tick_stb) begin
      o_level <= level_nxt;
    end
  end

endmodule

`default_nettype wire

/* design/pattern_sequencer.sv */
`default_nettype none
`timescale 1ns/10ps

module pattern_sequencer #(
  parameter int PAT_DEPTH = 8
) (
  input  wire                           i_clk,
  input  wire                           i_rst,
  input  wire                           i_wr_en,
  input  wire [$clog2(PAT_DEPTH)-1:0]   i_wr_addr,
  input  wire chan_pkg::note_entry_t    i_wr_entry,
  input  wire                           i_fetch,
  output logic                          o_valid,
  output chan_pkg::note_entry_t         o_entry
);

  import chan_pkg::*;

  localparam int ADDR_W = $clog2(PAT_DEPTH);

  note_entry_t       pat_mem [PAT_DEPTH];
  logic [ADDR_W-1:0] rd_ptr;

  // Pattern table, loaded while the channel is idle
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      pat_mem[i_wr_addr] <= i_wr_entry;
    end
    if (i_fetch) begin
      o_entry <= pat_mem[rd_ptr];
    end
  end

  // Read pointer steps once per fetch and wraps at the table end
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_ptr  <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_fetch;
      if (i_fetch) begin
        rd_ptr <= (rd_ptr == ADDR_W'(PAT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/pitch_lookup.sv */
`default_nettype none
`timescale 1ns/10ps

module pitch_lookup (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire                          i_enable,
  input  wire [chan_pkg::NOTE_W-1:0]   i_note,
  output logic                         o_valid,
  output logic [chan_pkg::PHASE_W-1:0] o_phase_inc
);

  import chan_pkg::*;

  // Increments run 16 to 31, times 4
  always_ff @(posedge i_clk) begin
    if (i_enable) begin
      case (i_note)
        4'd0:    o_phase_inc <= PHASE_W'(64);
        4'd1:    o_phase_inc <= PHASE_W'(68);
        4'd2:    o_phase_inc <= PHASE_W'(72);
        4'd3:    o_phase_inc <= PHASE_W'(76);
        4'd4:    o_phase_inc <= PHASE_W'(80);
        4'd5:    o_phase_inc <= PHASE_W'(84);
        4'd6:    o_phase_inc <= PHASE_W'(88);
        4'd7:    o_phase_inc <= PHASE_W'(92);
        4'd8:    o_phase_inc <= PHASE_W'(96);
        4'd9:    o_phase_inc <= PHASE_W'(100);
        4'd10:   o_phase_inc <= PHASE_W'(104);
        4'd11:   o_phase_inc <= PHASE_W'(108);
        4'd12:   o_phase_inc <= PHASE_W'(112);
        4'd13:   o_phase_inc <= PHASE_W'(116);
        4'd14:   o_phase_inc <= PHASE_W'(120);
        default: o_phase_inc <= PHASE_W'(124);
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_enable;
    end
  end

endmodule

`default_nettype wire

/* design/tone_oscillator.sv */
`default_nettype none
`timescale 1ns/10ps

module tone_oscillator (
  input  wire   i_clk,
  input  wire   i_rst,
  input  wire   i_tick_stb,
  note_if.osc   note,
  output logic  o_polarity
);

  import chan_pkg::*;

  logic [PHASE_W-1:0] phase_acc;

  // Phase restarts at each note and advances once per tick
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      phase_acc <= '0;
    end else if (note.load) begin
      phase_acc <= '0;
    end else if (i_tick_stb) begin
      phase_acc <= phase_acc + note.phase_inc;
    end
  end

  // Square wave from the accumulator MSB
  assign o_polarity = phase_acc[PHASE_W-1];

endmodule

`default_nettype wire

/* design/tracker_channel.sv */
`default_nettype none
`timescale 1ns/10ps

// Note parameters handed from the controller to the voice blocks
interface note_if;
  import chan_pkg::*;
  logic               load;
  logic [PHASE_W-1:0] phase_inc;
  logic [AMP_W-1:0]   peak;
  logic [DECAY_W-1:0] decay;
  modport ctrl (output load, output phase_inc, output peak, output decay);
  modport osc  (input load, input phase_inc);
  modport env  (input load, input peak, input decay);
endinterface

module tracker_channel #(
  parameter int PAT_DEPTH  = 8,
  parameter int FIFO_DEPTH = 4,
  parameter int CREDIT_MAX = 4
) (
  input  wire                           i_clk,
  input  wire                           i_rst,
  input  wire                           i_tick_stb,
  input  wire                           i_note_stb,
  input  wire                           i_wr_en,
  input  wire [$clog2(PAT_DEPTH)-1:0]   i_wr_addr,
  input  wire chan_pkg::note_entry_t    i_wr_entry,
  input  wire                           i_credit,
  output wire                           o_sample_valid,
  output wire chan_pkg::sample_t        o_sample,
  output wire                           o_overrun
);

  import chan_pkg::*;

  logic               fetch;
  logic               pat_valid;
  note_entry_t        pat_entry;
  logic               pitch_enable;
  logic               pitch_valid;
  logic [PHASE_W-1:0] phase_inc;
  logic               polarity;
  logic [AMP_W-1:0]   level;

  note_if note_bus ();

  pattern_sequencer #(.PAT_DEPTH(PAT_DEPTH)) u_sequencer (
    .i_clk(i_clk), .i_rst(i_rst), .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr),
    .i_wr_entry(i_wr_entry), .i_fetch(fetch), .o_valid(pat_valid), .o_entry(pat_entry)
  );

  pitch_lookup u_pitch (
    .i_clk(i_clk), .i_rst(i_rst), .i_enable(pitch_enable), .i_note(pat_entry.note),
    .o_valid(pitch_valid), .o_phase_inc(phase_inc)
  );

  channel_controller u_controller (
    .i_clk(i_clk), .i_rst(i_rst), .i_tick_stb(i_tick_stb), .i_note_stb(i_note_stb),
    .o_fetch(fetch), .i_pattern_valid(pat_valid), .i_entry(pat_entry),
    .o_pitch_enable(pitch_enable), .i_pitch_valid(pitch_valid), .i_phase_inc(phase_inc),
    .note(note_bus.ctrl)
  );

  tone_oscillator u_oscillator (
    .i_clk(i_clk), .i_rst(i_rst), .i_tick_stb(i_tick_stb), .note(note_bus.osc),
    .o_polarity(polarity)
  );

  envelope_generator u_envelope (
    .i_clk(i_clk), .i_rst(i_rst), .i_tick_stb(i_tick_stb), .note(note_bus.env),
    .o_level(level)
  );

  channel_mixer #(.FIFO_DEPTH(FIFO_DEPTH), .CREDIT_MAX(CREDIT_MAX)) u_mixer (
    .i_clk(i_clk), .i_rst(i_rst), .i_tick_stb(i_tick_stb), .i_polarity(polarity),
    .i_level(level), .i_credit(i_credit), .o_sample_valid(o_sample_valid),
    .o_sample(o_sample), .o_overrun(o_overrun)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the tracker channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tracker_channel_tb -f all.f -Mdir "$BUILD_DIR" -o tracker_channel_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tracker_channel_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* testbench/tracker_channel_golden.txt */
// Hex words; each @ line places one section
// Header: tick count, expected sample count, credit schedule entries
@00
28 25 4
// Pattern entries, packed {note, duration, peak, decay}
@08
3D321 08057 205E2 00FFB 14944 28C50 14944 28C50
// Pitch table for reference: phase increment of notes 0 to 15
@10
40 44 48 4C 50 54 58 5C
60 64 68 6C 70 74 78 7C
// Credit schedule: tick index, credit level held from that tick on
@20
00 0
03 1
14 0
1E 1
// Expected samples in delivery order, ticks 28 to 30 dropped on a full queue
@30
00 9C 9D 9E 9F A0 A1 A2
A3 A4 A5 A6 A7 A8 A9 AA
AB AC 53 52 51 F6 FD 00
00 C4 C6 C8 D0 D2 81 84
87 8A 8D 90 93

/* testbench/tracker_channel_props.sv */
`default_nettype none
`timescale 1ns/10ps

module tracker_channel_props #(
  parameter int CREDIT_MAX = 4
) (
  input wire i_clk,
  input wire i_rst,
  input wire i_sample_valid,
  input wire i_credit,
  input wire i_load,
  input wire i_fetch,
  input wire i_dur_busy
);

  int fail_cnt = 0;
  int credit_model;
  int credit_next;

  // Credit count rebuilt from grants and deliveries at the ports
  // Spend comes first so a full count still takes a grant in the same cycle
  always_comb begin
    credit_next = credit_model;
    if (i_sample_valid && credit_next > 0) begin
      credit_next = credit_next - 1;
    end
    if (i_credit && credit_next < CREDIT_MAX) begin
      credit_next = credit_next + 1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      credit_model <= 0;
    end else begin
      credit_model <= credit_next;
    end
  end

  // A delivery spends a credit that is already held
  a_valid_has_credit: assert property (
    @(posedge i_clk) disable iff (i_rst) i_sample_valid |-> credit_model != 0
  ) else begin
    fail_cnt++;
    $error("sample valid with zero credits");
  end

  a_load_one_cycle: assert property (
    @(posedge i_clk) disable iff (i_rst) i_load |=> !i_load
  ) else begin
    fail_cnt++;
    $error("load strobe wider than one cycle");
  end

  // Next entry only once the running note has expired
  a_fetch_when_expired: assert property (
    @(posedge i_clk) disable iff (i_rst) i_fetch |-> !i_dur_busy
  ) else begin
    fail_cnt++;
    $error("fetch while the duration count is nonzero");
  end

endmodule

bind channel_mixer tracker_channel_props #(.CREDIT_MAX(CREDIT_MAX)) mixer_props (
  .i_clk(i_clk), .i_rst(i_rst), .i_sample_valid(o_sample_valid),
  .i_credit(i_credit), .i_load(1'b0), .i_fetch(1'b0), .i_dur_busy(1'b0)
);

bind channel_controller tracker_channel_props ctrl_props (
  .i_clk(i_clk), .i_rst(i_rst), .i_sample_valid(1'b0), .i_credit(1'b0),
  .i_load(note.load), .i_fetch(o_fetch), .i_dur_busy(dur_cnt != '0)
);

`default_nettype wire

/* testbench/tracker_channel_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module tracker_channel_tb;

  import chan_pkg::*;

  localparam int PAT_DEPTH  = 8;
  localparam int FIFO_DEPTH = 4;
  localparam int CREDIT_MAX = 4;
  localparam int ADDR_W     = $clog2(PAT_DEPTH);
  localparam int DRIVE_DLY  = 2;

  // Section bases inside the golden image
  localparam int PAT_BASE    = 'h08;
  localparam int CREDIT_BASE = 'h20;
  localparam int SAMPLE_BASE = 'h30;

  // Cycles allowed for the queue to drain after the last tick
  localparam int DRAIN_LIMIT = 400;

  logic              i_clk;
  logic              i_rst;
  logic              i_tick_stb;
  logic              i_note_stb;
  logic              i_wr_en;
  logic [ADDR_W-1:0] i_wr_addr;
  note_entry_t       i_wr_entry;
  logic              i_credit;
  logic              o_sample_valid;
  sample_t           o_sample;
  logic              o_overrun;

  logic [31:0] golden [128];
  int          tick_count = 0;
  int          exp_count = 0;
  int          credit_count = 0;
  int          rx_count = 0;
  int          sample_errors = 0;
  int          flag_errors = 0;
  int          other_errors = 0;
  logic        credit_granted = 1'b0;

  tracker_channel #(
    .PAT_DEPTH(PAT_DEPTH),
    .FIFO_DEPTH(FIFO_DEPTH),
    .CREDIT_MAX(CREDIT_MAX)
  ) tracker_channel_inst (
    .i_clk(i_clk), .i_rst(i_rst), .i_tick_stb(i_tick_stb), .i_note_stb(i_note_stb),
    .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_entry(i_wr_entry),
    .i_credit(i_credit), .o_sample_valid(o_sample_valid), .o_sample(o_sample),
    .o_overrun(o_overrun)
  );

  always #20 i_clk = ~i_clk;

  task automatic step_cycles(input int n);
    repeat (n) @(posedge i_clk);
    #DRIVE_DLY;
  endtask

  task automatic check_sample(input sample_t got, input sample_t exp, input int idx);
    if (got !== exp) begin
      sample_errors++;
      $display("MISMATCH at %0t: sample %0d is %0d, expected %0d", $time, idx, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic load_pattern();
    for (int i = 0; i < PAT_DEPTH; i++) begin
      i_wr_en    = 1'b1;
      i_wr_addr  = ADDR_W'(i);
      i_wr_entry = note_entry_t'(golden[PAT_BASE + i][$bits(note_entry_t)-1:0]);
      step_cycles(1);
    end
    i_wr_en = 1'b0;
  endtask

  // Every 4th tick starts a note, spacing jitters between 8 and 10 cycles
  task automatic run_ticks();
    int credit_idx;
    int gap;
    credit_idx = 0;
    for (int n = 0; n < tick_count; n++) begin
      // Credit level switches together with the tick the schedule names
      if (credit_idx < credit_count && golden[CREDIT_BASE + 2 * credit_idx] == 32'(n)) begin
        i_credit = golden[CREDIT_BASE + 2 * credit_idx + 1][0];
        credit_idx++;
      end
      i_tick_stb = 1'b1;
      i_note_stb = (n % 4 == 0);
      step_cycles(1);
      i_tick_stb = 1'b0;
      i_note_stb = 1'b0;
      gap = 8 + int'($urandom % 3);
      step_cycles(gap - 1);
    end
  endtask

  task automatic wait_for_samples(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (rx_count < target && cycles < limit) begin
      @(posedge i_clk);
      cycles++;
    end
    if (rx_count < target) begin
      other_errors++;
      $display("Timeout after %0d cycles waiting for %0d samples, only %0d delivered",
               limit, target, rx_count);
    end
  endtask

  always @(posedge i_clk) begin
    if (i_credit) begin
      credit_granted <= 1'b1;
    end
  end

  // Sampled mid-cycle, each valid cycle is one delivery
  always @(negedge i_clk) begin
    if (!i_rst && o_sample_valid) begin
      if (!credit_granted) begin
        other_errors++;
        $display("Sample delivered at %0t before any credit was granted", $time);
      end
      if (rx_count < exp_count) begin
        check_sample(o_sample, sample_t'(golden[SAMPLE_BASE + rx_count][$bits(sample_t)-1:0]),
                     rx_count);
      end else begin
        other_errors++;
        $display("Extra sample %0d delivered at %0t beyond the expected list", rx_count, $time);
      end
      rx_count++;
    end
  end

  initial begin
    int   seed;
    int   assert_errors;
    logic exp_overrun;
    i_clk      = 1'b0;
    i_rst      = 1'b1;
    i_tick_stb = 1'b0;
    i_note_stb = 1'b0;
    i_wr_en    = 1'b0;
    i_wr_addr  = '0;
    i_wr_entry = '0;
    i_credit   = 1'b0;
    seed       = 3528;
    void'($urandom(seed));
    $readmemh("testbench/tracker_channel_golden.txt", golden);
    tick_count   = int'(golden[0]);
    exp_count    = int'(golden[1]);
    credit_count = int'(golden[2]);

    repeat (2) @(posedge i_clk);
    #DRIVE_DLY;
    i_rst = 1'b0;

    load_pattern();
    // Idle with no credit and no ticks, nothing may come out
    step_cycles(8);
    check_flag(o_overrun, 1'b0, "o_overrun while idle");

    run_ticks();
    wait_for_samples(exp_count, DRAIN_LIMIT);
    step_cycles(20);

    // Overrun is sticky once any tick was dropped
    exp_overrun = (exp_count < tick_count);
    check_flag(o_overrun, exp_overrun, "o_overrun after the run");

    assert_errors = tracker_channel_inst.u_mixer.mixer_props.fail_cnt
                  + tracker_channel_inst.u_controller.ctrl_props.fail_cnt;
    $display("Error counts: sample %0d, flag %0d, assertion %0d, other %0d",
             sample_errors, flag_errors, assert_errors, other_errors);
    if (sample_errors + flag_errors + assert_errors + other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
